/* Makefile */
# Verilator build and run of the scope testbench

BIN  := obj_dir/scope_tb
SRCS := $(shell grep -v '^+' files.f) include/scope_config.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert --top-module scope_tb -Mdir obj_dir -o scope_tb -f files.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/scope_sva.sv */
// APB handshake and interrupt checks; bound into scope_apb_regs, sampled on adc_clk
`timescale 1ns/1ns

module scope_sva (
  input logic adc_clk,
  input logic top_rst,
  input logic psel_i,
  input logic penable_i,
  input logic pready_o,
  input logic pslverr_o,
  input logic irq_o
);

  // ready only inside an access phase
  ap_ready_in_access: assert property (@(posedge adc_clk) disable iff (top_rst)
    pready_o |-> (psel_i && penable_i))
    else $error("pready high outside an APB access phase");

  // error only on the completing cycle
  ap_err_with_ready: assert property (@(posedge adc_clk) disable iff (top_rst)
    pslverr_o |-> pready_o)
    else $error("pslverr high without pready");

  ap_irq_in_reset: assert property (@(posedge adc_clk) top_rst |-> !irq_o)
    else $error("irq high during reset");

endmodule

bind scope_apb_regs scope_sva i_sva (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o),
  .irq_o     (irq_o)
);

/* bench/scope_tb.sv */
// directed tests for 2 channels of 16 samples with APB on adc_clk; the run stops at the first error
`timescale 1ns/1ns
`include "scope_config.svh"

module scope_tb;

  import scope_sample_pkg::*;
  import scope_reg_pkg::*;

  // channel window bases
  // CH2 lies past the last channel
  localparam apb_addr_t CH0 = 10'h000;
  localparam apb_addr_t CH1 = 10'h080;
  localparam apb_addr_t CH2 = 10'h100;
  // magnitude bits that the offset-binary code inverts
  localparam adc_raw_t MAG_MASK = {1'b0, {(`SCOPE_ADC_W-1){1'b1}}};

  logic                         adc_clk;
  logic                         top_rst;
  adc_raw_t [`SCOPE_NUM_CH-1:0] adc_dat;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  apb_addr_t                    paddr;
  apb_data_t                    pwdata;
  apb_data_t                    prdata;
  logic                         pready;
  logic                         pslverr;
  logic                         irq;

  // words applied to the ADC pins at the next drive slot
  adc_raw_t    adc_next [`SCOPE_NUM_CH];
  // raw words fed to the channel under test at one per cycle
  adc_raw_t    seq [$];
  logic        last_err;
  logic [31:0] lcg_state;

  scope_top i_scope_top (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .irq_o     (irq)
  );

  // 40 ns period
  always #20 adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // keep the sign bit and invert the magnitude
  function automatic sample_t conv(adc_raw_t raw);
    return sample_t'(raw ^ MAG_MASK);
  endfunction

  // raw code whose converted value is s
  function automatic void drive(int ch, sample_t s);
    adc_next[ch] = adc_raw_t'(s) ^ MAG_MASK;
  endfunction

  function automatic apb_addr_t reg_addr(apb_addr_t base, reg_off_t off);
    return base + apb_addr_t'(off);
  endfunction

  // one clock edge and inputs change 2 ns later
  task automatic step_clk();
    @(posedge adc_clk);
    #2;
    for (int i = 0; i < `SCOPE_NUM_CH; i++) begin
      adc_dat[i] = adc_next[i];
    end
  endtask

  task automatic fail_now(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic cmp_data(string test, apb_data_t exp, apb_data_t act);
    if (exp !== act) begin
      fail_now($sformatf("ERR %s expected 0x%08h actual 0x%08h", test, exp, act));
    end
  endtask

  task automatic cmp_sample(string test, sample_t exp, sample_t act);
    if (exp !== act) begin
      fail_now($sformatf("ERR %s expected %0d actual %0d", test, exp, act));
    end
  endtask

  task automatic cmp_state(string test, acq_state_t exp, acq_state_t act);
    if (exp !== act) begin
      fail_now($sformatf("ERR %s expected %s actual %0d", test, exp.name(), act));
    end
  endtask

  // pslverr and irq levels
  task automatic cmp_bit(string test, logic exp, logic act);
    if (exp !== act) begin
      fail_now($sformatf("ERR %s expected %0b actual %0b", test, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////

  // setup cycle then access cycles until pready
  task automatic apb_xfer(logic wr, apb_addr_t addr, apb_data_t wdata, output apb_data_t rdata);
    int waits;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    step_clk();
    penable = 1'b1;
    waits = 0;
    while (!pready) begin
      if (waits == 8) fail_now("APB transfer timed out waiting for pready");
      step_clk();
      waits++;
    end
    rdata = prdata;
    last_err = pslverr;
    // transfer completes on this edge
    step_clk();
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(apb_addr_t addr, apb_data_t data);
    apb_data_t unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(apb_addr_t addr, output apb_data_t data);
    apb_xfer(1'b0, addr, '0, data);
  endtask

  task automatic reg_wr(string test, apb_addr_t addr, apb_data_t data);
    apb_write(addr, data);
    cmp_bit(test, 1'b0, last_err);
  endtask

  task automatic reg_chk(string test, apb_addr_t addr, apb_data_t exp);
    apb_data_t rd;
    apb_read(addr, rd);
    cmp_bit(test, 1'b0, last_err);
    cmp_data(test, exp, rd);
  endtask

  task automatic state_chk(string test, apb_addr_t base, acq_state_t exp);
    apb_data_t rd;
    apb_read(reg_addr(base, REG_STATUS), rd);
    cmp_bit(test, 1'b0, last_err);
    cmp_state(test, exp, acq_state_t'(rd[2:0]));
  endtask

  // poll STATUS until the channel reaches exp
  task automatic wait_state(string test, apb_addr_t base, acq_state_t exp, int max_polls);
    apb_data_t rd;
    int polls;
    polls = 0;
    apb_read(reg_addr(base, REG_STATUS), rd);
    while (acq_state_t'(rd[2:0]) != exp) begin
      if (polls == max_polls) begin
        fail_now($sformatf("%s: channel never reached %s", test, exp.name()));
      end
      apb_read(reg_addr(base, REG_STATUS), rd);
      polls++;
    end
  endtask

  task automatic wait_irq(string test, logic val, int max_cycles);
    int cnt;
    cnt = 0;
    while (irq !== val) begin
      if (cnt == max_cycles) fail_now($sformatf("%s: irq did not settle in time", test));
      step_clk();
      cnt++;
    end
  endtask

  // locate the trigger in seq by the edge rule
  // the window ends at post-sample n
  task automatic check_buffer(string test, apb_addr_t base, sample_t lvl, logic fall, int n);
    apb_data_t rd;
    sample_t   prv;
    sample_t   cur;
    int        trg;
    int        first;
    trg = -1;
    for (int k = 1; k < seq.size() && trg < 0; k++) begin
      prv = conv(seq[k-1]);
      cur = conv(seq[k]);
      if (fall ? (prv > lvl && cur <= lvl) : (prv < lvl && cur >= lvl)) trg = k;
    end
    first = trg - (int'(BUF_DEPTH) - n);
    if (trg < 0 || first < 0) fail_now($sformatf("%s: no trigger crossing was driven", test));
    for (int i = 0; i < int'(BUF_DEPTH); i++) begin
      apb_read(reg_addr(base, reg_off_t'(REG_BUF_BASE + 4 * i)), rd);
      cmp_bit(test, 1'b0, last_err);
      cmp_sample(test, conv(seq[first + i]), sample_t'(rd[15:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    apb_addr_t base;
    cmp_bit("reset irq", 1'b0, irq);
    cmp_bit("reset pready", 1'b0, pready);
    cmp_bit("reset pslverr", 1'b0, pslverr);
    cmp_data("reset prdata", '0, prdata);
    for (int i = 0; i < `SCOPE_NUM_CH; i++) begin
      base = apb_addr_t'(i) * CH_STRIDE;
      state_chk("reset status", base, ACQ_IDLE);
      reg_chk("reset ctrl", reg_addr(base, REG_CTRL), 32'd0);
      reg_chk("reset level", reg_addr(base, REG_LEVEL), 32'd0);
      reg_chk("reset post", reg_addr(base, REG_POST), 32'd8);
    end
  endtask

  // ramp of +7 from 650 through level 1000 with post count 8
  task automatic test_rising();
    apb_data_t rd;
    sample_t   s;
    sample_t   exp_trg;
    int        cnt;
    s = sample_t'(650);
    drive(0, s);
    reg_wr("rise cfg", reg_addr(CH0, REG_LEVEL), 32'd1000);
    reg_wr("rise cfg", reg_addr(CH0, REG_POST), 32'd8);
    reg_wr("rise arm", reg_addr(CH0, REG_CTRL), 32'h1);
    wait_state("rise armed", CH0, ACQ_ARMED, 20);
    seq.delete();
    cnt = 0;
    while (!irq) begin
      if (cnt == 200) fail_now("rising trigger: channel 0 raised no interrupt");
      s = sample_t'(s + 7);
      drive(0, s);
      seq.push_back(adc_next[0]);
      step_clk();
      cnt++;
    end
    check_buffer("rise buffer", CH0, sample_t'(1000), 1'b0, 8);
    // first ramp value at or above the level sits at post-sample 1
    exp_trg = sample_t'(650);
    while (exp_trg < sample_t'(1000)) exp_trg = sample_t'(exp_trg + 7);
    apb_read(reg_addr(CH0, reg_off_t'(REG_BUF_BASE + 4 * 8)), rd);
    cmp_sample("rise trigger sample", exp_trg, sample_t'(rd[15:0]));
  endtask

  // channel 0 parked below a high level while channel 1 falls through -500
  task automatic test_falling();
    sample_t lvl;
    sample_t s;
    int      cnt;
    lvl = sample_t'(-500);
    drive(0, sample_t'(0));
    drive(1, sample_t'(2000));
    reg_wr("fall cfg", reg_addr(CH0, REG_LEVEL), 32'h7000);
    reg_wr("fall arm", reg_addr(CH0, REG_CTRL), 32'h1);
    reg_wr("fall cfg", reg_addr(CH1, REG_LEVEL), apb_data_t'(lvl));
    reg_wr("fall cfg", reg_addr(CH1, REG_POST), 32'd4);
    reg_wr("fall arm", reg_addr(CH1, REG_CTRL), 32'h3);
    wait_state("fall armed", CH1, ACQ_ARMED, 20);
    seq.delete();
    cnt = 0;
    while (!irq) begin
      if (cnt == 100) fail_now("falling trigger: channel 1 raised no interrupt");
      // 20 random words above the level and then at or below it
      if (cnt < 20) s = sample_t'(lvl + 1 + int'(lcg_next() % 6000));
      else s = sample_t'(lvl - int'(lcg_next() % 6000));
      drive(1, s);
      seq.push_back(adc_next[1]);
      step_clk();
      cnt++;
    end
    check_buffer("fall buffer", CH1, lvl, 1'b1, 4);
    state_chk("fall ch0 still armed", CH0, ACQ_ARMED);
  endtask

  task automatic test_irq();
    // channel 0 crosses 0x7000 at once
    drive(0, sample_t'(30720));
    wait_state("irq ch0 done", CH0, ACQ_DONE, 20);
    cmp_bit("irq both done", 1'b1, irq);
    reg_wr("irq clear ch0", reg_addr(CH0, REG_STATUS), 32'h8);
    state_chk("irq ch0 cleared", CH0, ACQ_IDLE);
    cmp_bit("irq held by ch1", 1'b1, irq);
    reg_wr("irq clear ch1", reg_addr(CH1, REG_STATUS), 32'h8);
    wait_irq("irq release", 1'b0, 4);
    state_chk("irq ch1 cleared", CH1, ACQ_IDLE);
    // new capture runs through FILL again
    reg_wr("irq rearm", reg_addr(CH1, REG_CTRL), 32'h3);
    state_chk("irq rearm fill", CH1, ACQ_FILL);
    wait_state("irq rearm armed", CH1, ACQ_ARMED, 20);
  endtask

  task automatic test_errors();
    apb_data_t rd;
    apb_write(reg_addr(CH0, REG_BUF_BASE), 32'h1234);
    cmp_bit("err buffer write", 1'b1, last_err);
    apb_read(reg_addr(CH2, REG_LEVEL), rd);
    cmp_bit("err channel 2 read", 1'b1, last_err);
    apb_write(reg_addr(CH2, REG_LEVEL), 32'h55);
    cmp_bit("err channel 2 write", 1'b1, last_err);
    apb_read(reg_addr(CH0, reg_off_t'(7'h10)), rd);
    cmp_bit("err unmapped", 1'b1, last_err);
    apb_write(reg_addr(CH1, REG_POST), 32'd0);
    cmp_bit("err post zero", 1'b1, last_err);
    reg_chk("err post kept", reg_addr(CH1, REG_POST), 32'd4);
    reg_chk("err level kept", reg_addr(CH0, REG_LEVEL), 32'h7000);
    reg_chk("err ctrl kept", reg_addr(CH1, REG_CTRL), 32'h2);
  endtask

  initial begin
    adc_clk = 1'b0;
    top_rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    last_err = 1'b0;
    lcg_state = 32'h3169;
    // mid-scale raw code gives sample 0
    for (int i = 0; i < `SCOPE_NUM_CH; i++) begin
      adc_next[i] = MAG_MASK;
      adc_dat[i] = MAG_MASK;
    end
    repeat (16) @(posedge adc_clk);
    #2;
    top_rst = 1'b0;
    test_reset();
    test_rising();
    test_falling();
    test_irq();
    test_errors();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
hw/scope_sample_pkg.sv
hw/scope_reg_pkg.sv
hw/acq_if.sv
hw/adc_frontend.sv
hw/osc_channel.sv
hw/scope_apb_regs.sv
hw/scope_top.sv
bench/scope_sva.sv
bench/scope_tb.sv

/* hw/acq_if.sv */
// one channel to register block link; arm and clear_done are single-cycle pulses
`timescale 1ns/1ns

interface acq_if;

  import scope_sample_pkg::*;

  // configuration from the register block
  // arm pulse, restarts capture
  logic      arm;
  // 0 rising, 1 falling
  logic      trg_edge;
  sample_t   level;
  post_cnt_t post_count;
  // clear pulse, leaves ACQ_DONE
  logic      clear_done;

  // buffer readback, index 0 is the oldest sample
  buf_addr_t rd_addr;
  // valid one cycle after rd_addr
  sample_t   rd_data;

  // channel FSM state
  acq_state_t state;

  modport regs (
    output arm, trg_edge, level, post_count, clear_done, rd_addr,
    input  state, rd_data
  );

  modport chan (
    input  arm, trg_edge, level, post_count, clear_done, rd_addr,
    output state, rd_data
  );

endinterface

/* hw/adc_frontend.sv */
// free-running ADC, no valid; reset parks each input at mid-scale so samples start at zero
`timescale 1ns/1ns
`include "scope_config.svh"

module adc_frontend (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  input  scope_sample_pkg::adc_raw_t [`SCOPE_NUM_CH-1:0] adc_dat_i,
  output scope_sample_pkg::sample_t  [`SCOPE_NUM_CH-1:0] smp_o
);

  import scope_sample_pkg::*;

  // mid-scale raw code, converts to sample 0
  localparam adc_raw_t RAW_ZERO = {1'b0, {(`SCOPE_ADC_W-1){1'b1}}};

  adc_raw_t [`SCOPE_NUM_CH-1:0] raw_q;

  // input registers, one stage for all channels
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_q <= {`SCOPE_NUM_CH{RAW_ZERO}};
    end else begin
      raw_q <= adc_dat_i;
    end
  end

  // negative slope offset binary to two's complement
  // keep sign bit, flip the rest
  for (genvar i = 0; i < `SCOPE_NUM_CH; i++) begin : g_conv
    assign smp_o[i] = {raw_q[i][`SCOPE_ADC_W-1], ~raw_q[i][`SCOPE_ADC_W-2:0]};
  end

endmodule

/* hw/osc_channel.sv */
// single channel capture; level and post count must stay stable while armed or in post
`timescale 1ns/1ns

module osc_channel (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  scope_sample_pkg::sample_t smp_i,
  acq_if.chan                       acq
);

  import scope_sample_pkg::*;

  ////////////////////////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////////////////////////

  acq_state_t state_q;
  acq_state_t state_d;

  // next write slot, also the oldest entry once 16 are written
  buf_addr_t wr_ptr;
  // samples written since arm
  buf_addr_t fill_cnt;
  // post-samples written, trigger sample is 1
  post_cnt_t post_cnt;

  sample_t prev_q;
  sample_t rd_q;
  logic    buf_we;
  logic    trig;

  // circular sample buffer
  sample_t mem [BUF_DEPTH];

  // write in every capturing state
  assign buf_we = (state_q == ACQ_FILL) || (state_q == ACQ_ARMED) || (state_q == ACQ_POST);

  // level crossing against the previous sample
  always_comb begin
    if (acq.trg_edge) begin
      // falling
      trig = (prev_q > acq.level) && (smp_i <= acq.level);
    end else begin
      // rising
      trig = (prev_q < acq.level) && (smp_i >= acq.level);
    end
  end

  // capture FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      ACQ_FILL: begin
        // 16th pre-trigger sample goes in this cycle
        if (fill_cnt == '1) state_d = ACQ_ARMED;
      end
      ACQ_ARMED: begin
        if (trig) begin
          state_d = (acq.post_count <= post_cnt_t'(1)) ? ACQ_DONE : ACQ_POST;
        end
      end
      ACQ_POST: begin
        // last post-sample written this cycle
        if (post_cnt + 1'b1 >= acq.post_count) state_d = ACQ_DONE;
      end
      ACQ_DONE: begin
        if (acq.clear_done) state_d = ACQ_IDLE;
      end
      default: ;
    endcase
    // arm wins from any state, including a restart from done
    if (acq.arm) state_d = ACQ_FILL;
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q  <= ACQ_IDLE;
      wr_ptr   <= '0;
      fill_cnt <= '0;
      post_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (buf_we) wr_ptr <= wr_ptr + 1'b1;
      // fill counter
      if (acq.arm) begin
        fill_cnt <= '0;
      end else if (state_q == ACQ_FILL) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      // post counter, preset while waiting for the trigger
      if (state_q == ACQ_ARMED) begin
        post_cnt <= post_cnt_t'(1);
      end else if (state_q == ACQ_POST) begin
        post_cnt <= post_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // buffer and previous sample
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    prev_q <= smp_i;
    if (buf_we) mem[wr_ptr] <= smp_i;
    // readback relative to the oldest entry
    rd_q <= mem[wr_ptr + acq.rd_addr];
  end

  assign acq.state   = state_q;
  assign acq.rd_data = rd_q;

endmodule

/* hw/scope_apb_regs.sv */
// APB slave for all channels; buffer reads take one wait state, erroring writes are dropped
`timescale 1ns/1ns
`include "scope_config.svh"

module scope_apb_regs (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  scope_reg_pkg::apb_addr_t paddr_i,
  input  scope_reg_pkg::apb_data_t pwdata_i,
  output scope_reg_pkg::apb_data_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output logic                     irq_o,
  acq_if.regs                      acq [`SCOPE_NUM_CH-1:0]
);

  import scope_sample_pkg::*;
  import scope_reg_pkg::*;

  // post count after reset, half the buffer
  localparam post_cnt_t POST_RST = post_cnt_t'(BUF_DEPTH / 2);

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  apb_addr_t win;
  ch_sel_t   ch;
  reg_off_t  off;
  buf_addr_t buf_idx;
  logic      ch_bad, is_reg, is_buf, post_bad, err;
  logic      setup, wr_en;

  // window index, bit 9 lands past the last channel
  assign win     = paddr_i / CH_STRIDE;
  assign ch      = ch_sel_t'(win);
  assign off     = reg_off_t'(paddr_i % CH_STRIDE);
  assign buf_idx = buf_addr_t'((off - REG_BUF_BASE) >> 2);

  assign ch_bad   = win >= apb_addr_t'(`SCOPE_NUM_CH);
  assign is_reg   = off inside {REG_CTRL, REG_LEVEL, REG_POST, REG_STATUS};
  assign is_buf   = (off >= REG_BUF_BASE) && (off[1:0] == 2'b00);
  // post count range 1..16
  assign post_bad = pwrite_i && (off == REG_POST) &&
                    ((pwdata_i == '0) || (pwdata_i > apb_data_t'(BUF_DEPTH)));
  assign err      = ch_bad || !(is_reg || is_buf) || (is_buf && pwrite_i) || post_bad;

  logic      pready_q, pslverr_q, buf_wait_q, irq_q;
  apb_data_t prdata_q;

  assign setup = psel_i && !penable_i;
  // writes land in the completing access cycle
  assign wr_en = psel_i && penable_i && pready_q && pwrite_i && !pslverr_q;

  ////////////////////////////////////////////////////////////
  // per-channel registers
  ////////////////////////////////////////////////////////////

  logic       [`SCOPE_NUM_CH-1:0] edge_q;
  sample_t    [`SCOPE_NUM_CH-1:0] level_q;
  post_cnt_t  [`SCOPE_NUM_CH-1:0] post_q;
  acq_state_t [`SCOPE_NUM_CH-1:0] st;
  sample_t    [`SCOPE_NUM_CH-1:0] rdd;
  logic       [`SCOPE_NUM_CH-1:0] done_vec;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      edge_q  <= '0;
      level_q <= '0;
      post_q  <= {`SCOPE_NUM_CH{POST_RST}};
    end else if (wr_en) begin
      for (int i = 0; i < `SCOPE_NUM_CH; i++) begin
        if (ch == ch_sel_t'(i)) begin
          case (off)
            REG_CTRL:  edge_q[i]  <= pwdata_i[CTRL_EDGE_BIT];
            REG_LEVEL: level_q[i] <= sample_t'(pwdata_i[`SCOPE_ADC_W-1:0]);
            REG_POST:  post_q[i]  <= post_cnt_t'(pwdata_i);
            default: ;
          endcase
        end
      end
    end
  end

  // channel links, pulses decoded straight from the write
  for (genvar i = 0; i < `SCOPE_NUM_CH; i++) begin : g_ch
    assign acq[i].arm        = wr_en && (ch == ch_sel_t'(i)) && (off == REG_CTRL) &&
                               pwdata_i[CTRL_ARM_BIT];
    assign acq[i].clear_done = wr_en && (ch == ch_sel_t'(i)) && (off == REG_STATUS) &&
                               pwdata_i[STAT_CLR_BIT];
    assign acq[i].trg_edge   = edge_q[i];
    assign acq[i].level      = level_q[i];
    assign acq[i].post_count = post_q[i];
    assign acq[i].rd_addr    = buf_idx;
    assign st[i]             = acq[i].state;
    assign rdd[i]            = acq[i].rd_data;
    assign done_vec[i]       = (acq[i].state == ACQ_DONE);
  end

  ////////////////////////////////////////////////////////////
  // read mux and APB sequencing
  ////////////////////////////////////////////////////////////

  apb_data_t reg_rdata;
  apb_data_t buf_rdata;

  always_comb begin
    reg_rdata = '0;
    buf_rdata = '0;
    for (int i = 0; i < `SCOPE_NUM_CH; i++) begin
      if (ch == ch_sel_t'(i)) begin
        // arm and clear bits read back as zero
        case (off)
          REG_CTRL:   reg_rdata = apb_data_t'(edge_q[i]) << CTRL_EDGE_BIT;
          REG_LEVEL:  reg_rdata = apb_data_t'(level_q[i]);
          REG_POST:   reg_rdata = apb_data_t'(post_q[i]);
          REG_STATUS: reg_rdata = apb_data_t'(st[i]);
          default: ;
        endcase
        // samples sign extended
        buf_rdata = apb_data_t'(rdd[i]);
      end
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pready_q   <= 1'b0;
      pslverr_q  <= 1'b0;
      prdata_q   <= '0;
      buf_wait_q <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      pready_q   <= 1'b0;
      pslverr_q  <= 1'b0;
      prdata_q   <= '0;
      buf_wait_q <= 1'b0;
      // any channel done
      irq_q      <= |done_vec;
      if (setup) begin
        if (is_buf && !err) begin
          // memory word arrives in the first access cycle
          buf_wait_q <= 1'b1;
        end else begin
          pready_q  <= 1'b1;
          pslverr_q <= err;
          if (!pwrite_i && !err) prdata_q <= reg_rdata;
        end
      end else if (buf_wait_q && psel_i && penable_i) begin
        pready_q <= 1'b1;
        prdata_q <= buf_rdata;
      end
    end
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;
  assign irq_o     = irq_q;

endmodule

/* hw/scope_reg_pkg.sv */
// APB register map; offsets are bytes inside one 0x80 channel window, data is 32 bits
`include "scope_config.svh"

package scope_reg_pkg;

  // full APB byte address
  typedef logic [`SCOPE_APB_AW-1:0] apb_addr_t;

  // APB data word
  typedef logic [31:0] apb_data_t;

  // channel index, address bits 8:7
  typedef logic [1:0] ch_sel_t;

  // byte offset inside a channel window
  typedef logic [6:0] reg_off_t;

  // window size per channel
  localparam apb_addr_t CH_STRIDE = 10'h080;

  ////////////////////////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////////////////////////

  localparam reg_off_t REG_CTRL     = 7'h00;
  localparam reg_off_t REG_LEVEL    = 7'h04;
  localparam reg_off_t REG_POST     = 7'h08;
  localparam reg_off_t REG_STATUS   = 7'h0C;
  // buffer words 0..15, one per 4 bytes
  localparam reg_off_t REG_BUF_BASE = 7'h40;

  // bit positions
  localparam int unsigned CTRL_ARM_BIT  = 0;
  localparam int unsigned CTRL_EDGE_BIT = 1;
  localparam int unsigned STAT_CLR_BIT  = 3;

endpackage

/* hw/scope_sample_pkg.sv */
// sample path types; widths come from scope_config.svh, buffer depth must be a power of two
`include "scope_config.svh"

package scope_sample_pkg;

  // raw converter word, negative-slope offset binary
  typedef logic [`SCOPE_ADC_W-1:0] adc_raw_t;

  // converted sample, two's complement
  typedef logic signed [`SCOPE_ADC_W-1:0] sample_t;

  // index into one channel buffer
  typedef logic [`SCOPE_BUF_AW-1:0] buf_addr_t;

  // post-trigger count, one bit wider so a full buffer fits
  typedef logic [`SCOPE_BUF_AW:0] post_cnt_t;

  localparam int unsigned BUF_DEPTH = 1 << `SCOPE_BUF_AW;

  // capture FSM, encoding is visible in STATUS bits 2:0
  typedef enum logic [2:0] {
    ACQ_IDLE  = 3'd0,
    ACQ_FILL  = 3'd1,
    ACQ_ARMED = 3'd2,
    ACQ_POST  = 3'd3,
    ACQ_DONE  = 3'd4
  } acq_state_t;

endpackage

/* hw/scope_top.sv */
// acquisition subsystem top on adc_clk; APB and ADC must share that clock
`timescale 1ns/1ns
`include "scope_config.svh"

module scope_top (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  // ADC words, one per channel
  input  scope_sample_pkg::adc_raw_t [`SCOPE_NUM_CH-1:0] adc_dat_i,
  // APB slave
  input  logic                                           psel_i,
  input  logic                                           penable_i,
  input  logic                                           pwrite_i,
  input  scope_reg_pkg::apb_addr_t                       paddr_i,
  input  scope_reg_pkg::apb_data_t                       pwdata_i,
  output scope_reg_pkg::apb_data_t                       prdata_o,
  output logic                                           pready_o,
  output logic                                           pslverr_o,
  // capture done, any channel
  output logic                                           irq_o
);

  import scope_sample_pkg::*;

  // converted samples
  sample_t [`SCOPE_NUM_CH-1:0] smp;

  // channel to register block links
  acq_if acq [`SCOPE_NUM_CH-1:0] ();

  adc_frontend u_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .smp_o     (smp)
  );

  ////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `SCOPE_NUM_CH; i++) begin : g_osc
    osc_channel u_chan (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (smp[i]),
      .acq     (acq[i])
    );
  end

  scope_apb_regs u_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .irq_o     (irq_o),
    .acq       (acq)
  );

endmodule

/* include/scope_config.svh */
// build-time sizing only; SCOPE_NUM_CH above 4 needs a wider channel field in the APB map
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// number of acquisition channels, 1 to 4
`define SCOPE_NUM_CH 2

// log2 of the per-channel sample buffer depth
`define SCOPE_BUF_AW 4

// ADC word width, offset binary from the converter
`define SCOPE_ADC_W 16

// APB byte address width, channel windows of 0x80 bytes
`define SCOPE_APB_AW 10

`endif
